// File: Makefile
TOP = fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: logic/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
  parameter fetch_pkg::word_t RESET_PC = fetch_pkg::RESET_PC_DEF
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             run,
  input  logic             branch_valid,
  input  fetch_pkg::word_t branch_target,
  input  logic             ihit,
  input  fetch_pkg::word_t instr,
  output logic             imem_ren,
  output fetch_pkg::word_t imem_addr,
  output logic             instr_valid,
  output fetch_pkg::word_t instr_out,
  output fetch_pkg::word_t instr_pc
);
  import fetch_pkg::*;

  // two-state run control
  typedef enum logic {
    halted   = 1'b0,
    fetching = 1'b1
  } fetch_state_t;

  fetch_state_t state, nxt_state;
  word_t        pc, nxt_pc;

  // state and pc registers
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= halted;
      pc    <= RESET_PC;
    end else begin
      state <= nxt_state;
      pc    <= nxt_pc;
    end
  end

  // run starts fetching on the next edge, dropping run halts at once
  always_comb begin
    nxt_state = state;
    case (state)
      halted:   if (run) nxt_state = fetching;
      fetching: if (!run) nxt_state = halted;
      default:  nxt_state = halted;
    endcase
  end

  // redirect wins over a sequential advance
  // a miss leaves the pc where it is until the refill lands
  always_comb begin
    nxt_pc = pc;
    if (branch_valid) begin
      nxt_pc = branch_target;
    end else if (ihit) begin
      nxt_pc = pc + PC_STEP;
    end
  end

  // request the instruction at the pc while running
  assign imem_ren  = (state == fetching) && run;
  assign imem_addr = pc;

  // the word under the pc is dropped in a branch cycle
  // that pc is on the wrong path
  assign instr_valid = ihit && !branch_valid;
  assign instr_out   = instr;
  assign instr_pc    = pc;

endmodule

// File: logic/fetch_pkg.sv
package fetch_pkg;

  // one machine word
  // instructions, memory data and byte addresses all use it
  typedef logic [31:0] word_t;

  // byte offset bits inside a word address
  localparam int BYTE_OFF_W = 2;

  // default number of index bits in the instruction cache
  // gives 2**4 = 16 one-word lines
  localparam int IIDX_W_DEF = 4;

  // default program counter after reset
  localparam word_t RESET_PC_DEF = 32'h0000_0000;

  // pc step for sequential fetch, one word in bytes
  localparam word_t PC_STEP = word_t'(1) << BYTE_OFF_W;

endpackage

// File: logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
  parameter int               IIDX_W   = fetch_pkg::IIDX_W_DEF,
  parameter fetch_pkg::word_t RESET_PC = fetch_pkg::RESET_PC_DEF
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             run,
  input  logic             branch_valid,
  input  fetch_pkg::word_t branch_target,
  input  logic             dren,
  input  logic             dwen,
  input  fetch_pkg::word_t daddr,
  input  fetch_pkg::word_t dstore,
  input  fetch_pkg::word_t ram_load,
  input  logic             ram_wait,
  output logic             instr_valid,
  output fetch_pkg::word_t instr_out,
  output fetch_pkg::word_t instr_pc,
  output logic             dwait,
  output fetch_pkg::word_t dload,
  output logic             ram_ren,
  output logic             ram_wen,
  output fetch_pkg::word_t ram_addr,
  output fetch_pkg::word_t ram_store
);
  import fetch_pkg::*;

  // fetch control to cache
  logic  imem_ren;
  word_t imem_addr;
  logic  ihit;
  word_t instr;

  // cache refill to arbiter
  logic  iren;
  word_t iaddr;
  logic  iwait;
  word_t iload;

  fetch_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
    .CLK, .nRST, .run, .branch_valid, .branch_target, .ihit, .instr,
    .imem_ren, .imem_addr, .instr_valid, .instr_out, .instr_pc
  );

  icache #(.IIDX_W(IIDX_W)) u_icache (
    .CLK, .nRST, .imem_ren, .imem_addr, .iwait, .iload,
    .ihit, .instr, .iren, .iaddr
  );

  mem_arbiter u_arb (
    .iren, .iaddr, .iwait, .iload,
    .dren, .dwen, .daddr, .dstore, .dwait, .dload,
    .ram_load, .ram_wait, .ram_ren, .ram_wen, .ram_addr, .ram_store
  );

endmodule

// File: logic/icache.sv
`timescale 1ns/1ps

module icache #(
  parameter int IIDX_W = fetch_pkg::IIDX_W_DEF
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             imem_ren,
  input  fetch_pkg::word_t imem_addr,
  input  logic             iwait,
  input  fetch_pkg::word_t iload,
  output logic             ihit,
  output fetch_pkg::word_t instr,
  output logic             iren,
  output fetch_pkg::word_t iaddr
);
  import fetch_pkg::*;

  // address layout is tag | index | byte offset
  localparam int TAG_W  = 32 - IIDX_W - BYTE_OFF_W;
  localparam int NLINES = 1 << IIDX_W;

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [IIDX_W-1:0] idx_t;

  // refill fsm
  typedef enum logic {
    idle = 1'b0,
    miss = 1'b1
  } icache_state_t;

  icache_state_t state, nxt_state;

  // line storage, one word per line
  logic  valid_q [NLINES];
  tag_t  tag_q   [NLINES];
  word_t data_q  [NLINES];

  // lookup fields of the fetch address
  tag_t  req_tag;
  idx_t  req_idx;

  // address of the line being refilled, held across the whole miss
  word_t miss_addr;
  tag_t  fill_tag;
  idx_t  fill_idx;
  logic  fill_en;

  assign req_tag = imem_addr[31 -: TAG_W];
  assign req_idx = imem_addr[BYTE_OFF_W +: IIDX_W];

  assign fill_tag = miss_addr[31 -: TAG_W];
  assign fill_idx = miss_addr[BYTE_OFF_W +: IIDX_W];

  // same-cycle hit on valid line with matching tag
  assign ihit  = imem_ren && valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign instr = data_q[req_idx];

  // the line is written in the first cycle the memory answers
  assign fill_en = (state == miss) && !iwait;

  // refill request stays up for the whole miss state
  assign iren  = (state == miss);
  assign iaddr = miss_addr;

  always_comb begin
    nxt_state = state;
    case (state)
      idle:    if (imem_ren && !ihit) nxt_state = miss;
      miss:    if (!iwait) nxt_state = idle;
      default: nxt_state = idle;
    endcase
  end

  // state and valid bits start cleared
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= idle;
      for (int i = 0; i < NLINES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      state <= nxt_state;
      if (fill_en) valid_q[fill_idx] <= 1'b1;
    end
  end

  // tag and data arrays and the refill address
  always_ff @(posedge CLK) begin
    // capture on entry so a later branch cannot move the refill
    if (state == idle && nxt_state == miss) miss_addr <= imem_addr;
    if (fill_en) begin
      tag_q[fill_idx]  <= fill_tag;
      data_q[fill_idx] <= iload;
    end
  end

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  // instruction refill side
  input  logic             iren,
  input  fetch_pkg::word_t iaddr,
  output logic             iwait,
  output fetch_pkg::word_t iload,
  // data side
  input  logic             dren,
  input  logic             dwen,
  input  fetch_pkg::word_t daddr,
  input  fetch_pkg::word_t dstore,
  output logic             dwait,
  output fetch_pkg::word_t dload,
  // shared memory port
  input  fetch_pkg::word_t ram_load,
  input  logic             ram_wait,
  output logic             ram_ren,
  output logic             ram_wen,
  output fetch_pkg::word_t ram_addr,
  output fetch_pkg::word_t ram_store
);

  // data side owns the port whenever it asks
  logic d_own;

  assign d_own = dren || dwen;

  // only the data side writes
  // a write wins over a read raised in the same cycle
  assign ram_wen = dwen;
  assign ram_ren = !dwen && (dren || iren);

  // address from the owner
  assign ram_addr  = d_own ? daddr : iaddr;
  assign ram_store = dstore;

  // owner sees the memory wait, the other side waits
  always_comb begin
    dwait = 1'b1;
    iwait = 1'b1;
    if (d_own) begin
      dwait = ram_wait;
    end else if (iren) begin
      iwait = ram_wait;
    end
  end

  // load data goes to both
  // only the owner reads it, when its wait is low
  assign dload = ram_load;
  assign iload = ram_load;

endmodule

// File: sources.f
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/icache.sv
logic/mem_arbiter.sv
logic/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv

// File: test/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
  input logic             CLK,
  input logic             nRST,
  input logic             imem_ren,
  input fetch_pkg::word_t imem_addr,
  input logic             ihit,
  input logic             iren,
  input fetch_pkg::word_t iaddr,
  input logic             iwait,
  input logic             branch_valid,
  input fetch_pkg::word_t branch_target
);

  // a stalled refill keeps its request and its address
  assert property (@(posedge CLK) disable iff (!nRST)
    iren && iwait |=> iren && $stable(iaddr))
    else $error("refill request dropped or moved while stalled");

  // a refilled line hits in the next cycle if the pc stayed on it
  assert property (@(posedge CLK) disable iff (!nRST)
    iren && !iwait && !branch_valid && (imem_addr == iaddr) |=> ihit || !imem_ren)
    else $error("refilled line did not hit on the following fetch");

  // redirect lands on the very next cycle
  assert property (@(posedge CLK) disable iff (!nRST)
    branch_valid |=> (imem_addr == $past(branch_target)))
    else $error("fetch address did not follow the branch target");

endmodule

// control and cache signals all meet at the top level
bind fetch_top fetch_checker u_checker (
  .CLK, .nRST, .imem_ren, .imem_addr, .ihit, .iren, .iaddr, .iwait,
  .branch_valid, .branch_target
);

// File: test/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int    IIDX_W      = 4;
  localparam word_t RESET_PC    = 32'h0000_0000;
  localparam int    ENTRY_LIMIT = 400;

  typedef enum int {
    act_run,
    act_branch,
    act_dread,
    act_dwrite
  } act_t;

  logic  CLK           = 1'b0;
  logic  nRST          = 1'b0;
  logic  run           = 1'b0;
  logic  branch_valid  = 1'b0;
  word_t branch_target = '0;
  // data side and memory, both driven by the memory model
  logic  dren          = 1'b0;
  logic  dwen          = 1'b0;
  word_t daddr         = '0;
  word_t dstore        = '0;
  word_t ram_load      = '0;
  logic  ram_wait      = 1'b1;
  logic  instr_valid;
  word_t instr_out;
  word_t instr_pc;
  logic  dwait;
  word_t dload;
  logic  ram_ren;
  logic  ram_wen;
  word_t ram_addr;
  word_t ram_store;

  // data job passed from the sequence to the memory model
  int    job_seq    = 0;
  logic  job_wr     = 1'b0;
  word_t job_addr   = '0;
  word_t job_data   = '0;
  int    job_taken  = 0;
  int    job_done   = 0;
  word_t job_result = '0;
  logic  job_wait   = 1'b1;

  // memory model state
  int    seed         = 32'h7147;
  int    ifetch_reads = 0;
  logic  busy         = 1'b0;
  int    left         = 0;
  word_t shadow [word_t];

  // stimulus table, one field per queue
  string q_name  [$];
  act_t  q_act   [$];
  word_t q_addr  [$];
  word_t q_data  [$];
  int    q_count [$];
  int    q_reads [$];

  // expected fetch stream
  word_t exp_pc = RESET_PC;
  int    got    = 0;

  fetch_top #(.IIDX_W(IIDX_W), .RESET_PC(RESET_PC)) UUT (.*);

  always #2 CLK = ~CLK;

  // upper half is the low address half, lower half its inverse
  function automatic word_t content_of(input word_t a);
    return {a[15:0], ~a[15:0]};
  endfunction

  function automatic word_t mem_read(input word_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return content_of(a);
  endfunction

  // memory with 0 to 3 random wait cycles, plus the data requester
  always @(posedge CLK) begin
    if (!nRST) begin
      ram_wait <= 1'b1;
      busy = 1'b0;
    end else if (!ram_wait && (ram_ren || ram_wen)) begin
      // access completes at this edge
      if (ram_wen && ram_addr >= 32'h0000_8000) begin
        shadow[ram_addr] = ram_store;
      end
      if (dren || dwen) begin
        dren       <= 1'b0;
        dwen       <= 1'b0;
        job_result <= dload;
        job_wait   <= dwait;
        job_done   <= job_taken;
      end else begin
        ifetch_reads <= ifetch_reads + 1;
      end
      ram_wait <= 1'b1;
      busy = 1'b0;
    end else if (job_seq != job_taken) begin
      // data takes the port, a running count starts over
      dren      <= !job_wr;
      dwen      <= job_wr;
      daddr     <= job_addr;
      dstore    <= job_data;
      job_taken <= job_seq;
      busy = 1'b0;
    end else if (ram_ren || ram_wen) begin
      if (!busy) begin
        busy = 1'b1;
        left = $unsigned($random(seed)) % 4;
      end
      if (left == 0) begin
        ram_wait <= 1'b0;
        ram_load <= mem_read(ram_addr);
      end else begin
        left = left - 1;
      end
    end
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // one clock, then check whatever instruction the cycle presented
  task automatic step_cycle(input string name);
    @(posedge CLK);
    if (instr_valid) begin
      check_word(name, exp_pc, instr_pc);
      check_word(name, content_of(exp_pc), instr_out);
      exp_pc = exp_pc + 32'd4;
      got = got + 1;
    end
  endtask

  task automatic add_entry(input string name, input act_t act, input word_t addr,
                           input word_t data, input int count, input int reads);
    q_name.push_back(name);
    q_act.push_back(act);
    q_addr.push_back(addr);
    q_data.push_back(data);
    q_count.push_back(count);
    q_reads.push_back(reads);
  endtask

  task automatic fill_table();
    add_entry("seq_start", act_run, 32'h0, 32'h0, 6, 6);
    add_entry("loop_pass1", act_branch, 32'h0000_0100, 32'h0, 8, 8);
    // whole loop now sits in the cache
    add_entry("loop_pass2", act_branch, 32'h0000_0100, 32'h0, 8, 0);
    add_entry("loop_pass3", act_branch, 32'h0000_0100, 32'h0, 8, 0);
    // 0x200 and 0x240 share index 0
    add_entry("evict_a", act_branch, 32'h0000_0200, 32'h0, 1, 1);
    add_entry("evict_b", act_branch, 32'h0000_0240, 32'h0, 1, 1);
    add_entry("evict_a2", act_branch, 32'h0000_0200, 32'h0, 1, 1);
    add_entry("evict_b2", act_branch, 32'h0000_0240, 32'h0, 1, 1);
    // data jobs run next to fetch misses
    add_entry("data_write", act_dwrite, 32'h0000_8010, 32'h1234_5678, 4, 4);
    add_entry("data_read_back", act_dread, 32'h0000_8010, 32'h1234_5678, 4, 4);
    add_entry("data_read_plain", act_dread, 32'h0000_0404, content_of(32'h0000_0404), 4, 4);
  endtask

  task automatic run_entry(input int i);
    int   reads0;
    int   cyc;
    logic want_data;
    logic done;
    reads0    = ifetch_reads;
    want_data = (q_act[i] == act_dread) || (q_act[i] == act_dwrite);
    got       = 0;
    run <= 1'b1;
    if (want_data) begin
      job_wr   <= (q_act[i] == act_dwrite);
      job_addr <= q_addr[i];
      job_data <= q_data[i];
      job_seq  <= job_seq + 1;
    end
    if (q_act[i] == act_branch) begin
      branch_valid  <= 1'b1;
      branch_target <= q_addr[i];
      exp_pc = q_addr[i];
      // redirect held into the first fetching cycle
      // a hit on a cached target must stay hidden there
      repeat (2) begin
        @(posedge CLK);
        check_flag(q_name[i], 1'b0, instr_valid);
      end
      branch_valid <= 1'b0;
    end
    done = 1'b0;
    for (cyc = 0; cyc < ENTRY_LIMIT && !done; cyc++) begin
      step_cycle(q_name[i]);
      if (got >= q_count[i]) run <= 1'b0;
      done = (got >= q_count[i]) && (!want_data || job_done == job_seq);
    end
    if (!done) begin
      $display("timeout in %s, fetch or data job did not finish", q_name[i]);
      abort_run();
    end
    // one quiet cycle lets the last counts settle
    step_cycle(q_name[i]);
    check_count(q_name[i], q_reads[i], ifetch_reads - reads0);
    if (want_data) begin
      check_flag(q_name[i], 1'b0, job_wait);
    end
    if (q_act[i] == act_dread) begin
      check_word(q_name[i], q_data[i], job_result);
    end
  endtask

  initial begin
    int i;
    fill_table();
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    // fetch stays quiet until run rises
    for (i = 0; i < 5; i++) begin
      step_cycle("idle_after_reset");
      check_flag("idle_after_reset", 1'b0, instr_valid);
      check_flag("idle_after_reset", 1'b0, ram_ren);
      check_flag("idle_after_reset", 1'b0, ram_wen);
    end
    for (i = 0; i < q_name.size(); i++) begin
      run_entry(i);
    end
    $display("Everything OK");
    $finish;
  end

endmodule
